//--- hdl/cnn_geom_pkg.sv
package cnn_geom_pkg;

    // ====================================================================
    // Fixed-point format
    // ====================================================================
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_BITS  = 7;

    // Nine 32-bit products need four guard bits
    localparam int ACC_WIDTH  = 36;

    // ====================================================================
    // Geometry
    // ====================================================================
    localparam int KERNEL       = 3;
    localparam int MAX_CHANNELS = 8;

    // Quantised pixels, weights, biases and lane results
    typedef logic signed [DATA_WIDTH-1:0] pixel_t;

    // Window sum before rescale
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // Byte 0..255 to round(k * 2^FRAC_BITS / 255)
    function automatic pixel_t quantise(input logic [7:0] k);
        int v;
        v = (int'(k) * (1 << FRAC_BITS) + 127) / 255;
        return pixel_t'(v);
    endfunction

endpackage

//--- hdl/cnn_weights_pkg.sv
package cnn_weights_pkg;

    // ====================================================================
    // Conv kernels in Q.7, indexed [channel][row][col]
    // ====================================================================
    localparam cnn_geom_pkg::pixel_t CONV_W
        [cnn_geom_pkg::MAX_CHANNELS][cnn_geom_pkg::KERNEL][cnn_geom_pkg::KERNEL] = '{
        // Centre pass with a small negative corner
        '{'{0, 0, 0}, '{0, 128, 0}, '{0, 0, -16}},
        // Horizontal edge
        '{'{-128, -128, -128}, '{0, 0, 0}, '{128, 128, 128}},
        // Vertical Sobel
        '{'{-64, 0, 64}, '{-128, 0, 128}, '{-64, 0, 64}},
        // Laplacian
        '{'{0, -128, 0}, '{-128, 512, -128}, '{0, -128, 0}},
        // Ring blur with a dipped centre
        '{'{16, 16, 16}, '{16, -32, 16}, '{16, 16, 16}},
        // Diagonal gradient
        '{'{96, 32, -48}, '{32, 0, -32}, '{48, -32, -96}},
        // Sharpen
        '{'{-32, -32, -32}, '{-32, 384, -32}, '{-32, -32, -32}},
        // High gain, saturates on bright input
        '{'{6000, 6000, 6000}, '{6000, -2000, 6000}, '{6000, 6000, 6000}}
    };

    // ====================================================================
    // Biases, already in output scale
    // ====================================================================
    localparam cnn_geom_pkg::pixel_t CONV_B [cnn_geom_pkg::MAX_CHANNELS] = '{
        0,
        4,
        -8,
        2,
        -6,
        10,
        -3,
        100
    };

endpackage

//--- hdl/pixel_window.sv
`timescale 1ns/1ps

module pixel_window #(
    parameter int IMG_SIZE     = 28,
    parameter int OUT_CHANNELS = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_valid,
    output logic                    pix_ready,
    input  logic [7:0]              pix_byte,
    input  logic [OUT_CHANNELS-1:0] lane_ready,
    output logic                    win_valid,
    output cnn_geom_pkg::pixel_t    win_taps [cnn_geom_pkg::KERNEL*cnn_geom_pkg::KERNEL],
    output logic                    win_last
);
    localparam int K     = cnn_geom_pkg::KERNEL;
    localparam int CNT_W = $clog2(IMG_SIZE);
    localparam logic [CNT_W-1:0] LAST_POS  = CNT_W'(IMG_SIZE - 1);
    localparam logic [CNT_W-1:0] FIRST_WIN = CNT_W'(K - 1);

    logic [CNT_W-1:0]     row;
    logic [CNT_W-1:0]     col;
    logic                 win_take;
    logic                 pix_take;
    logic                 at_window;
    logic                 at_end;
    cnn_geom_pkg::pixel_t q_pix;

    // Row r-1 and row r-2 of the frame
    cnn_geom_pkg::pixel_t line1 [IMG_SIZE];
    cnn_geom_pkg::pixel_t line2 [IMG_SIZE];

    // ====================================================================
    // Handshakes
    // ====================================================================
    // All lanes run in lockstep, so the window moves only when all are ready
    assign win_take  = win_valid && (&lane_ready);

    // A pending window blocks input unless it leaves this cycle
    assign pix_ready = !win_valid || win_take;
    assign pix_take  = pix_valid && pix_ready;

    assign at_window = (row >= FIRST_WIN) && (col >= FIRST_WIN);
    assign at_end    = (row == LAST_POS) && (col == LAST_POS);

    assign q_pix = cnn_geom_pkg::quantise(pix_byte);

    // ====================================================================
    // Raster position and window flags
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            row       <= '0;
            col       <= '0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            if (win_take) begin
                win_valid <= 1'b0;
            end
            if (pix_take) begin
                win_valid <= at_window;
                win_last  <= at_window && at_end;
                if (col == LAST_POS) begin
                    col <= '0;
                    // Wrap to the top so the next frame follows directly
                    row <= (row == LAST_POS) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // ====================================================================
    // Line buffers and 3x3 shift window
    // ====================================================================
    always_ff @(posedge clk) begin
        if (pix_take) begin
            line1[col] <= q_pix;
            line2[col] <= line1[col];

            // Shift every row one column to the left
            for (int i = 0; i < K; i++) begin
                for (int j = 0; j < K - 1; j++) begin
                    win_taps[i*K+j] <= win_taps[i*K+j+1];
                end
            end

            // New right column, oldest row on top
            win_taps[K-1]   <= line2[col];
            win_taps[2*K-1] <= line1[col];
            win_taps[K*K-1] <= q_pix;
        end
    end

endmodule

//--- hdl/conv_lane.sv
`timescale 1ns/1ps

module conv_lane #(
    parameter int CHANNEL = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 win_valid,
    input  cnn_geom_pkg::pixel_t win_taps [cnn_geom_pkg::KERNEL*cnn_geom_pkg::KERNEL],
    input  logic                 win_last,
    output logic                 lane_ready,
    output logic                 res_valid,
    output cnn_geom_pkg::pixel_t res_data,
    output logic                 res_last,
    input  logic                 bank_ready
);
    localparam int K    = cnn_geom_pkg::KERNEL;
    localparam int TAPS = K * K;
    localparam cnn_geom_pkg::acc_t SAT_MAX =
        cnn_geom_pkg::acc_t'((1 << (cnn_geom_pkg::DATA_WIDTH - 1)) - 1);

    cnn_geom_pkg::acc_t   prod [TAPS];
    cnn_geom_pkg::acc_t   sum;
    cnn_geom_pkg::acc_t   biased;
    cnn_geom_pkg::pixel_t clamped;
    logic                 s1_valid;
    logic                 s1_last;
    logic                 s2_adv;

    // Stage two frees up when empty or when the serializer takes it
    assign s2_adv     = !res_valid || bank_ready;
    assign lane_ready = !s1_valid || s2_adv;

    // ====================================================================
    // Stage two arithmetic
    // ====================================================================
    always_comb begin
        sum = '0;
        for (int k = 0; k < TAPS; k++) begin
            sum = sum + prod[k];
        end
    end

    // Arithmetic shift floors toward minus infinity
    assign biased = (sum >>> cnn_geom_pkg::FRAC_BITS)
                  + cnn_geom_pkg::acc_t'(cnn_weights_pkg::CONV_B[CHANNEL]);

    // ReLU then saturate
    always_comb begin
        if (biased < 0) begin
            clamped = '0;
        end else if (biased > SAT_MAX) begin
            clamped = cnn_geom_pkg::pixel_t'(SAT_MAX);
        end else begin
            clamped = cnn_geom_pkg::pixel_t'(biased);
        end
    end

    // ====================================================================
    // Pipeline registers
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (lane_ready) begin
                s1_valid <= win_valid;
            end
            if (s2_adv) begin
                res_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lane_ready) begin
            s1_last <= win_last;
            for (int k = 0; k < TAPS; k++) begin
                prod[k] <= win_taps[k] * cnn_weights_pkg::CONV_W[CHANNEL][k/K][k%K];
            end
        end
        if (s2_adv) begin
            res_data <= clamped;
            res_last <= s1_last;
        end
    end

endmodule

//--- hdl/channel_serializer.sv
`timescale 1ns/1ps

module channel_serializer #(
    parameter int OUT_CHANNELS = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [OUT_CHANNELS-1:0] res_valid,
    input  cnn_geom_pkg::pixel_t    res_data [OUT_CHANNELS],
    input  logic [OUT_CHANNELS-1:0] res_last,
    output logic                    bank_ready,
    output logic                    out_valid,
    input  logic                    out_ready,
    output cnn_geom_pkg::pixel_t    out_data,
    output logic [2:0]              out_channel,
    output logic                    out_last
);
    localparam logic [2:0] LAST_CH = 3'(OUT_CHANNELS - 1);

    cnn_geom_pkg::pixel_t bank [OUT_CHANNELS];
    logic                 bank_full;
    logic                 bank_last;
    logic                 bank_load;
    logic                 beat_take;
    logic [2:0]           chan;

    // Lanes are in lockstep, so all valid bits agree
    assign bank_ready = !bank_full;
    assign bank_load  = bank_ready && (&res_valid);
    assign beat_take  = bank_full && out_ready;

    assign out_valid   = bank_full;
    assign out_data    = bank[chan];
    assign out_channel = chan;
    assign out_last    = bank_last && (chan == LAST_CH);

    // ====================================================================
    // Bank state and channel walk
    // ====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_full <= 1'b0;
            chan      <= '0;
        end else if (bank_load) begin
            bank_full <= 1'b1;
            chan      <= '0;
        end else if (beat_take) begin
            if (chan == LAST_CH) begin
                bank_full <= 1'b0;
                chan      <= '0;
            end else begin
                chan <= chan + 1'b1;
            end
        end
    end

    // One result per lane, held until the last channel leaves
    always_ff @(posedge clk) begin
        if (bank_load) begin
            bank      <= res_data;
            bank_last <= &res_last;
        end
    end

endmodule

//--- hdl/cnn_conv_top.sv
`timescale 1ns/1ps

module cnn_conv_top #(
    parameter int IMG_SIZE     = 28,
    parameter int OUT_CHANNELS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pix_valid,
    output logic                 pix_ready,
    input  logic [7:0]           pix_byte,
    output logic                 out_valid,
    input  logic                 out_ready,
    output cnn_geom_pkg::pixel_t out_data,
    output logic [2:0]           out_channel,
    output logic                 out_last
);
    localparam int TAPS = cnn_geom_pkg::KERNEL * cnn_geom_pkg::KERNEL;

    // Window bus, shared by every lane
    logic                    win_valid;
    logic                    win_last;
    cnn_geom_pkg::pixel_t    win_taps [TAPS];
    logic [OUT_CHANNELS-1:0] lane_ready;

    // Lane result bus
    logic [OUT_CHANNELS-1:0] res_valid;
    logic [OUT_CHANNELS-1:0] res_last;
    cnn_geom_pkg::pixel_t    res_data [OUT_CHANNELS];
    logic                    bank_ready;

    // ====================================================================
    // Window generator
    // ====================================================================
    pixel_window #(
        .IMG_SIZE     (IMG_SIZE),
        .OUT_CHANNELS (OUT_CHANNELS)
    ) u_window (
        .clk, .reset,
        .pix_valid, .pix_ready, .pix_byte,
        .lane_ready,
        .win_valid, .win_taps, .win_last
    );

    // ====================================================================
    // One convolution lane per output channel
    // ====================================================================
    for (genvar ch = 0; ch < OUT_CHANNELS; ch++) begin : g_lane
        conv_lane #(
            .CHANNEL (ch)
        ) u_lane (
            .clk, .reset,
            .win_valid, .win_taps, .win_last,
            .lane_ready (lane_ready[ch]),
            .res_valid  (res_valid[ch]),
            .res_data   (res_data[ch]),
            .res_last   (res_last[ch]),
            .bank_ready
        );
    end

    // ====================================================================
    // Channel serializer
    // ====================================================================
    channel_serializer #(
        .OUT_CHANNELS (OUT_CHANNELS)
    ) u_serializer (
        .clk, .reset,
        .res_valid, .res_data, .res_last,
        .bank_ready,
        .out_valid, .out_ready, .out_data, .out_channel, .out_last
    );

endmodule

//--- tb/tb_cnn_conv.sv
`timescale 1ns/1ps

module tb_cnn_conv;

    localparam int IMG_SIZE     = 8;
    localparam int OUT_CHANNELS = 8;
    localparam int FRAME_PIX    = IMG_SIZE * IMG_SIZE;
    localparam int FRAME_BEATS  = (IMG_SIZE - 2) * (IMG_SIZE - 2) * OUT_CHANNELS;
    localparam int TIMEOUT      = 2000;
    localparam longint PIX_MAX  = 32767;
    localparam logic [31:0] SEED = 32'hf003f87e;

    localparam logic [1:0] KIND_CONST = 2'd0;
    localparam logic [1:0] KIND_RAMP  = 2'd1;
    localparam logic [1:0] KIND_LFSR  = 2'd2;

    // Value is the constant byte, the ramp step or the OR mask for LFSR bytes
    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] value;
        logic       backpressure;
    } frame_entry_t;

    // ====================================================================
    // Stimulus table, all frames sent back to back
    // ====================================================================
    localparam int NUM_FRAMES = 6;
    localparam frame_entry_t FRAME_TABLE [NUM_FRAMES] = '{
        '{KIND_CONST, 8'd255, 1'b0},
        '{KIND_CONST, 8'd0,   1'b0},
        '{KIND_RAMP,  8'd4,   1'b0},
        '{KIND_LFSR,  8'h80,  1'b0},
        '{KIND_LFSR,  8'h80,  1'b1},
        '{KIND_RAMP,  8'd3,   1'b1}
    };

    logic                 clk;
    logic                 reset;
    logic                 pix_valid;
    logic                 pix_ready;
    logic [7:0]           pix_byte;
    logic                 out_valid;
    logic                 out_ready;
    cnn_geom_pkg::pixel_t out_data;
    logic [2:0]           out_channel;
    logic                 out_last;

    logic [7:0]  pix_q [$];
    longint      exp_data [$];
    int          exp_channel [$];
    int          exp_last [$];
    logic [31:0] pattern_state;
    logic [31:0] ready_state;
    int          beats_seen;

    cnn_conv_top #(
        .IMG_SIZE     (IMG_SIZE),
        .OUT_CHANNELS (OUT_CHANNELS)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pix_byte    (pix_byte),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_last    (out_last)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ====================================================================
    // Helpers
    // ====================================================================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    task automatic stop_with(input string why);
        $display("ERROR: %s", why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input longint got, input longint expected);
        if (got !== expected) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, expected);
            stop_with("value mismatch");
        end
    endtask

    // Pixels of one table entry plus the expected beats of the reference model
    task automatic build_frame(input int f);
        frame_entry_t e;
        logic [7:0]   img;
        logic [31:0]  bits;
        longint       q [FRAME_PIX];
        longint       acc;
        longint       v;
        e = FRAME_TABLE[f];
        // Reseeded per frame so equal LFSR entries give equal frames
        pattern_state = SEED;
        for (int p = 0; p < FRAME_PIX; p++) begin
            case (e.kind)
                KIND_CONST: img = e.value;
                KIND_RAMP:  img = 8'(p * e.value);
                default: begin
                    draw_bits(pattern_state, 8, bits);
                    img = bits[7:0] | e.value;
                end
            endcase
            pix_q.push_back(img);
            q[p] = longint'(cnn_geom_pkg::quantise(img));
        end
        for (int r = 2; r < IMG_SIZE; r++) begin
            for (int c = 2; c < IMG_SIZE; c++) begin
                for (int ch = 0; ch < OUT_CHANNELS; ch++) begin
                    acc = 0;
                    for (int i = 0; i < 3; i++) begin
                        for (int j = 0; j < 3; j++) begin
                            acc += q[(r - 2 + i) * IMG_SIZE + (c - 2 + j)]
                                 * longint'(cnn_weights_pkg::CONV_W[ch][i][j]);
                        end
                    end
                    // Floor rescale, bias, ReLU and saturation
                    v = (acc >>> cnn_geom_pkg::FRAC_BITS)
                      + longint'(cnn_weights_pkg::CONV_B[ch]);
                    if (v < 0) begin
                        v = 0;
                    end else if (v > PIX_MAX) begin
                        v = PIX_MAX;
                    end
                    exp_data.push_back(v);
                    exp_channel.push_back(ch);
                    exp_last.push_back((r == IMG_SIZE - 1) && (c == IMG_SIZE - 1)
                                       && (ch == OUT_CHANNELS - 1));
                end
            end
        end
    endtask

    task automatic send_pixels();
        int waited;
        while (pix_q.size() > 0) begin
            @(negedge clk);
            pix_valid = 1'b1;
            pix_byte  = pix_q.pop_front();
            waited    = 0;
            while (!pix_ready) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    stop_with("pix_ready stayed low too long");
                end
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic collect_results();
        int          total;
        int          waited;
        logic [31:0] bits;
        total  = exp_data.size();
        waited = 0;
        while (beats_seen < total) begin
            @(negedge clk);
            if (FRAME_TABLE[beats_seen / FRAME_BEATS].backpressure) begin
                draw_bits(ready_state, 1, bits);
                out_ready = bits[0];
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin
                check_value("out_data", out_data, exp_data.pop_front());
                check_value("out_channel", out_channel, exp_channel.pop_front());
                check_value("out_last", out_last, exp_last.pop_front());
                beats_seen++;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    stop_with("no output beat arrived before the timeout");
                end
            end
        end
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================
    initial begin
        pix_valid     = 1'b0;
        pix_byte      = 8'd0;
        out_ready     = 1'b0;
        reset         = 1'b1;
        pattern_state = SEED;
        ready_state   = SEED;
        beats_seen    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle after reset
        repeat (5) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("pix_ready", pix_ready, 1);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_frame(f);
        end

        fork
            send_pixels();
            collect_results();
        join

        // Nothing may follow the last expected beat
        out_ready = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- sources.f
hdl/cnn_geom_pkg.sv
hdl/cnn_weights_pkg.sv
hdl/pixel_window.sv
hdl/conv_lane.sv
hdl/channel_serializer.sv
hdl/cnn_conv_top.sv
tb/tb_cnn_conv.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cnn_conv

rm -rf obj_dir "$LOG"

if ! verilator --binary --timing -Wno-fatal --top-module "$TOP" -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/V"$TOP" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "TEST OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
